// ==== evt_streamer_settings.svh ====
// widths, event codes and byte enable shared by the event streamer RTL
// include this in every file that uses these values
`ifndef EVT_STREAMER_SETTINGS_SVH
`define EVT_STREAMER_SETTINGS_SVH

// memory byte address and event word
`define EVT_ADDR_W 32
`define EVT_DATA_W 32
// transfer counter
`define EVT_CNT_W 16

// type nibble of an event word
`define EVT_TYPE_MSB 31
`define EVT_TYPE_LSB 28
`define EVT_EOP_CODE 4'hF

// every access is a full word
`define EVT_BE_ALL 4'b1111

`endif

// ==== evt_streamer_pkg.sv ====
// types shared by the event streamer engines, arbiter and top level
// refer to them as evt_streamer_pkg::name
`default_nettype none

`include "evt_streamer_settings.svh"

package evt_streamer_pkg;

  typedef logic [`EVT_ADDR_W-1:0] addr_t;
  typedef logic [`EVT_DATA_W-1:0] word_t;
  typedef logic [`EVT_CNT_W-1:0]  count_t;

  // transfer-end bit above the 4-bit state code
  typedef logic [4:0] status_t;

  typedef enum logic [3:0] {
    LD_RESET,
    LD_IDLE,
    LD_INIT,
    LD_STREAM,
    LD_PAUSE,
    LD_DRAIN,
    LD_TRANSFER_END
  } load_state_e;

  typedef enum logic [3:0] {
    ST_RESET,
    ST_IDLE,
    ST_INIT,
    ST_STREAM,
    ST_TRANSFER_END
  } store_state_e;

endpackage

`default_nettype wire

// ==== tcdm_port_if.sv ====
// one requester's side of the shared TCDM port
// engines take the requester modport, the arbiter the arbiter modport
`timescale 1ns/1ns
`default_nettype none

`include "evt_streamer_settings.svh"

interface tcdm_port_if;

  logic                    req;
  evt_streamer_pkg::addr_t addr;
  // high for a read
  logic                    wen;
  evt_streamer_pkg::word_t wdata;
  logic                    gnt;
  logic                    rdata_valid;

  modport requester (output req, addr, wen, wdata, input gnt, rdata_valid);

  modport arbiter (input req, addr, wen, wdata, output gnt, rdata_valid);

endinterface

`default_nettype wire

// ==== tcdm_arbiter.sv ====
// round-robin sharing of the single TCDM master port between load and store engines
// a waiting request keeps the port until it is granted
`timescale 1ns/1ns
`default_nettype none

`include "evt_streamer_settings.svh"

module tcdm_arbiter (
  input  wire logic               system_clk_i,
  input  wire logic               system_rst_ni,
  tcdm_port_if.arbiter            ld,
  tcdm_port_if.arbiter            st,
  output logic                    tcdm_req_o,
  input  wire logic               tcdm_gnt_i,
  output evt_streamer_pkg::addr_t tcdm_add_o,
  output logic                    tcdm_wen_o,
  output logic [3:0]              tcdm_be_o,
  output evt_streamer_pkg::word_t tcdm_data_o,
  input  wire logic               tcdm_r_valid_i
);

  // store engine had the last grant
  logic last_st_q;
  // a request went ungranted last cycle
  logic hold_q;
  logic hold_st_q;
  logic sel_st;

  always_comb begin
    if (hold_q && (hold_st_q ? st.req : ld.req)) begin
      sel_st = hold_st_q;
    end else begin
      sel_st = st.req && (!ld.req || !last_st_q);
    end
  end

  assign tcdm_req_o  = ld.req || st.req;
  assign tcdm_add_o  = sel_st ? st.addr : ld.addr;
  assign tcdm_wen_o  = sel_st ? st.wen : ld.wen;
  assign tcdm_data_o = sel_st ? st.wdata : ld.wdata;
  assign tcdm_be_o   = `EVT_BE_ALL;

  assign ld.gnt = tcdm_gnt_i && ld.req && !sel_st;
  assign st.gnt = tcdm_gnt_i && sel_st;

  // only the load engine issues reads
  assign ld.rdata_valid = tcdm_r_valid_i;
  assign st.rdata_valid = 1'b0;

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      last_st_q <= 1'b0;
      hold_q    <= 1'b0;
      hold_st_q <= 1'b0;
    end else begin
      hold_q    <= tcdm_req_o && !tcdm_gnt_i;
      hold_st_q <= sel_st;
      if (tcdm_req_o && tcdm_gnt_i) begin
        last_st_q <= sel_st;
      end
    end
  end

  // every granted beat goes to exactly one engine, and no grant goes to none
  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    (ld.gnt || st.gnt) == (tcdm_req_o && tcdm_gnt_i));

  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    tcdm_req_o && tcdm_gnt_i |-> (ld.gnt ^ st.gnt));

endmodule

`default_nettype wire

// ==== evt_load_engine.sv ====
// load engine: reads a block of TCDM words onto the outgoing event stream
// a stalled word waits in the pause register, an EOP word ends the block
`timescale 1ns/1ns
`default_nettype none

`include "evt_streamer_settings.svh"

module evt_load_engine (
  input  wire logic                     system_clk_i,
  input  wire logic                     system_rst_ni,
  input  wire logic                     ld_arm_i,
  input  wire logic                     ld_start_i,
  input  wire logic                     ld_end_mode_i,
  input  wire evt_streamer_pkg::addr_t  ld_start_addr_i,
  input  wire evt_streamer_pkg::addr_t  ld_addr_step_i,
  input  wire evt_streamer_pkg::addr_t  ld_end_addr_i,
  input  wire evt_streamer_pkg::count_t ld_tran_size_i,
  tcdm_port_if.requester                tcdm,
  input  wire evt_streamer_pkg::word_t  rdata_i,
  output logic                          src_valid_o,
  input  wire logic                     src_ready_i,
  output evt_streamer_pkg::word_t       src_evt_o,
  output evt_streamer_pkg::status_t     status_o
);

  evt_streamer_pkg::load_state_e state_q;
  evt_streamer_pkg::load_state_e state_d;
  evt_streamer_pkg::addr_t       addr_q;
  evt_streamer_pkg::addr_t       addr_next;
  evt_streamer_pkg::count_t      cnt_q;
  evt_streamer_pkg::count_t      cnt_next;
  evt_streamer_pkg::word_t       pause_q;
  logic                          inflight_q;
  logic                          end_now;
  logic                          end_after_gnt;
  logic                          gnt_fire;
  logic                          live_valid;
  logic                          paused;
  logic                          evt_is_eop;
  logic                          eop_taken;

  assign addr_next = addr_q + ld_addr_step_i;
  assign cnt_next  = cnt_q + 1'b1;

  // end mode high compares the address, low the word count
  assign end_now       = ld_end_mode_i ? (addr_q >= ld_end_addr_i) : (cnt_q == ld_tran_size_i);
  assign end_after_gnt = ld_end_mode_i ? (addr_next >= ld_end_addr_i)
                                       : (cnt_next == ld_tran_size_i);

  assign tcdm.req   = (state_q == evt_streamer_pkg::LD_STREAM) && src_ready_i && !end_now;
  assign tcdm.addr  = addr_q;
  assign tcdm.wen   = 1'b1;
  assign tcdm.wdata = '0;
  assign gnt_fire   = tcdm.req && tcdm.gnt;

  // a response counts only if its read was not issued alongside an EOP
  assign live_valid  = tcdm.rdata_valid && inflight_q;
  assign paused      = (state_q == evt_streamer_pkg::LD_PAUSE);
  assign src_valid_o = paused || live_valid;
  assign src_evt_o   = paused ? pause_q : rdata_i;
  assign evt_is_eop  = (src_evt_o[`EVT_TYPE_MSB:`EVT_TYPE_LSB] == `EVT_EOP_CODE);
  assign eop_taken   = src_valid_o && src_ready_i && evt_is_eop;
  assign status_o    = {state_q == evt_streamer_pkg::LD_TRANSFER_END, state_q};

  always_comb begin
    state_d = state_q;
    case (state_q)
      evt_streamer_pkg::LD_RESET: begin
        state_d = ld_arm_i ? evt_streamer_pkg::LD_IDLE : evt_streamer_pkg::LD_RESET;
      end
      evt_streamer_pkg::LD_IDLE: begin
        state_d = ld_start_i ? evt_streamer_pkg::LD_INIT : evt_streamer_pkg::LD_IDLE;
      end
      evt_streamer_pkg::LD_INIT: begin
        state_d = evt_streamer_pkg::LD_STREAM;
      end
      evt_streamer_pkg::LD_STREAM: begin
        if (live_valid && !src_ready_i) begin
          state_d = evt_streamer_pkg::LD_PAUSE;
        end else if (eop_taken || end_now || (gnt_fire && end_after_gnt)) begin
          state_d = evt_streamer_pkg::LD_DRAIN;
        end
      end
      evt_streamer_pkg::LD_PAUSE: begin
        if (src_ready_i) begin
          state_d = (evt_is_eop || end_now) ? evt_streamer_pkg::LD_DRAIN
                                            : evt_streamer_pkg::LD_STREAM;
        end
      end
      // last granted word comes back here
      evt_streamer_pkg::LD_DRAIN: begin
        state_d = (src_valid_o && !src_ready_i) ? evt_streamer_pkg::LD_PAUSE
                                                : evt_streamer_pkg::LD_TRANSFER_END;
      end
      evt_streamer_pkg::LD_TRANSFER_END: begin
        state_d = ld_start_i ? evt_streamer_pkg::LD_TRANSFER_END : evt_streamer_pkg::LD_IDLE;
      end
      default: begin
        state_d = evt_streamer_pkg::LD_IDLE;
      end
    endcase
  end

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      state_q    <= evt_streamer_pkg::LD_RESET;
      addr_q     <= '0;
      cnt_q      <= '0;
      inflight_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      inflight_q <= gnt_fire && !eop_taken;
      if (state_q == evt_streamer_pkg::LD_INIT) begin
        addr_q <= ld_start_addr_i;
        cnt_q  <= '0;
      end else if (gnt_fire) begin
        addr_q <= addr_next;
        cnt_q  <= cnt_next;
      end
    end
  end

  // keeps the returned word for a stalled stream
  always_ff @(posedge system_clk_i) begin
    if (live_valid) begin
      pause_q <= rdata_i;
    end
  end

  // a stalled word stays offered and unchanged until it is taken
  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    src_valid_o && !src_ready_i |=> src_valid_o && $stable(src_evt_o));

  // this engine only ever reads
  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    tcdm.req |-> tcdm.wen);

endmodule

`default_nettype wire

// ==== evt_store_engine.sv ====
// store engine: writes words from the incoming event stream into a TCDM block
// the write grant is handed back as the stream ready
`timescale 1ns/1ns
`default_nettype none

`include "evt_streamer_settings.svh"

module evt_store_engine (
  input  wire logic                     system_clk_i,
  input  wire logic                     system_rst_ni,
  input  wire logic                     st_arm_i,
  input  wire logic                     st_start_i,
  input  wire logic                     st_end_mode_i,
  input  wire evt_streamer_pkg::addr_t  st_start_addr_i,
  input  wire evt_streamer_pkg::addr_t  st_addr_step_i,
  input  wire evt_streamer_pkg::addr_t  st_end_addr_i,
  input  wire evt_streamer_pkg::count_t st_tran_size_i,
  tcdm_port_if.requester                tcdm,
  input  wire logic                     dst_valid_i,
  output logic                          dst_ready_o,
  input  wire evt_streamer_pkg::word_t  dst_evt_i,
  output evt_streamer_pkg::status_t     status_o
);

  evt_streamer_pkg::store_state_e state_q;
  evt_streamer_pkg::store_state_e state_d;
  evt_streamer_pkg::addr_t        addr_q;
  evt_streamer_pkg::count_t       cnt_q;
  logic                           end_now;

  // address at or past the end, or the full word count
  assign end_now = st_end_mode_i ? (addr_q >= st_end_addr_i) : (cnt_q == st_tran_size_i);

  assign tcdm.req    = (state_q == evt_streamer_pkg::ST_STREAM) && dst_valid_i && !end_now;
  assign tcdm.addr   = addr_q;
  assign tcdm.wen    = 1'b0;
  assign tcdm.wdata  = dst_evt_i;
  assign dst_ready_o = tcdm.req && tcdm.gnt;
  assign status_o    = {state_q == evt_streamer_pkg::ST_TRANSFER_END, state_q};

  always_comb begin
    state_d = state_q;
    case (state_q)
      evt_streamer_pkg::ST_RESET: begin
        state_d = st_arm_i ? evt_streamer_pkg::ST_IDLE : evt_streamer_pkg::ST_RESET;
      end
      evt_streamer_pkg::ST_IDLE: begin
        state_d = st_start_i ? evt_streamer_pkg::ST_INIT : evt_streamer_pkg::ST_IDLE;
      end
      evt_streamer_pkg::ST_INIT: begin
        state_d = evt_streamer_pkg::ST_STREAM;
      end
      evt_streamer_pkg::ST_STREAM: begin
        state_d = end_now ? evt_streamer_pkg::ST_TRANSFER_END : evt_streamer_pkg::ST_STREAM;
      end
      evt_streamer_pkg::ST_TRANSFER_END: begin
        state_d = st_start_i ? evt_streamer_pkg::ST_TRANSFER_END : evt_streamer_pkg::ST_IDLE;
      end
      default: begin
        state_d = evt_streamer_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      state_q <= evt_streamer_pkg::ST_RESET;
      addr_q  <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == evt_streamer_pkg::ST_INIT) begin
        addr_q <= st_start_addr_i;
        cnt_q  <= '0;
      end else if (dst_ready_o) begin
        addr_q <= addr_q + st_addr_step_i;
        cnt_q  <= cnt_q + 1'b1;
      end
    end
  end

  // the arbiter grant must only ever accept an offered word
  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    dst_ready_o |-> dst_valid_i);

endmodule

`default_nettype wire

// ==== evt_streamer_top.sv ====
// event streamer top: load and store engines sharing one TCDM master port
// configuration, status and both event streams are plain ports
`timescale 1ns/1ns
`default_nettype none

`include "evt_streamer_settings.svh"

module evt_streamer_top (
  input  wire logic                     system_clk_i,
  input  wire logic                     system_rst_ni,
  // tcdm master port
  output logic                          tcdm_req_o,
  input  wire logic                     tcdm_gnt_i,
  output evt_streamer_pkg::addr_t       tcdm_add_o,
  output logic                          tcdm_wen_o,
  output logic [3:0]                    tcdm_be_o,
  output evt_streamer_pkg::word_t       tcdm_data_o,
  input  wire evt_streamer_pkg::word_t  tcdm_r_data_i,
  input  wire logic                     tcdm_r_valid_i,
  // load engine
  input  wire logic                     ld_arm_i,
  input  wire logic                     ld_start_i,
  input  wire logic                     ld_end_mode_i,
  input  wire evt_streamer_pkg::addr_t  ld_start_addr_i,
  input  wire evt_streamer_pkg::addr_t  ld_addr_step_i,
  input  wire evt_streamer_pkg::addr_t  ld_end_addr_i,
  input  wire evt_streamer_pkg::count_t ld_tran_size_i,
  output logic                          src_valid_o,
  input  wire logic                     src_ready_i,
  output evt_streamer_pkg::word_t       src_evt_o,
  output evt_streamer_pkg::status_t     ld_status_o,
  // store engine
  input  wire logic                     st_arm_i,
  input  wire logic                     st_start_i,
  input  wire logic                     st_end_mode_i,
  input  wire evt_streamer_pkg::addr_t  st_start_addr_i,
  input  wire evt_streamer_pkg::addr_t  st_addr_step_i,
  input  wire evt_streamer_pkg::addr_t  st_end_addr_i,
  input  wire evt_streamer_pkg::count_t st_tran_size_i,
  input  wire logic                     dst_valid_i,
  output logic                          dst_ready_o,
  input  wire evt_streamer_pkg::word_t  dst_evt_i,
  output evt_streamer_pkg::status_t     st_status_o
);

  tcdm_port_if ld_port ();
  tcdm_port_if st_port ();

  evt_load_engine u_load (
    .system_clk_i    (system_clk_i),
    .system_rst_ni   (system_rst_ni),
    .ld_arm_i        (ld_arm_i),
    .ld_start_i      (ld_start_i),
    .ld_end_mode_i   (ld_end_mode_i),
    .ld_start_addr_i (ld_start_addr_i),
    .ld_addr_step_i  (ld_addr_step_i),
    .ld_end_addr_i   (ld_end_addr_i),
    .ld_tran_size_i  (ld_tran_size_i),
    .tcdm            (ld_port.requester),
    .rdata_i         (tcdm_r_data_i),
    .src_valid_o     (src_valid_o),
    .src_ready_i     (src_ready_i),
    .src_evt_o       (src_evt_o),
    .status_o        (ld_status_o)
  );

  evt_store_engine u_store (
    .system_clk_i    (system_clk_i),
    .system_rst_ni   (system_rst_ni),
    .st_arm_i        (st_arm_i),
    .st_start_i      (st_start_i),
    .st_end_mode_i   (st_end_mode_i),
    .st_start_addr_i (st_start_addr_i),
    .st_addr_step_i  (st_addr_step_i),
    .st_end_addr_i   (st_end_addr_i),
    .st_tran_size_i  (st_tran_size_i),
    .tcdm            (st_port.requester),
    .dst_valid_i     (dst_valid_i),
    .dst_ready_o     (dst_ready_o),
    .dst_evt_i       (dst_evt_i),
    .status_o        (st_status_o)
  );

  tcdm_arbiter u_arbiter (
    .system_clk_i   (system_clk_i),
    .system_rst_ni  (system_rst_ni),
    .ld             (ld_port.arbiter),
    .st             (st_port.arbiter),
    .tcdm_req_o     (tcdm_req_o),
    .tcdm_gnt_i     (tcdm_gnt_i),
    .tcdm_add_o     (tcdm_add_o),
    .tcdm_wen_o     (tcdm_wen_o),
    .tcdm_be_o      (tcdm_be_o),
    .tcdm_data_o    (tcdm_data_o),
    .tcdm_r_valid_i (tcdm_r_valid_i)
  );

endmodule

`default_nettype wire

// ==== tb_tcdm_model.sv ====
// behavioral TCDM for the testbench: random grant, read data one cycle after the grant
// words start from a fill of their own index, and every granted write is logged in order
`timescale 1ns/1ns
`default_nettype none

module tb_tcdm_model (
  input  wire logic        system_clk_i,
  input  wire logic        system_rst_ni,
  input  wire logic        req_i,
  input  wire logic [31:0] addr_i,
  input  wire logic        wen_i,
  input  wire logic [31:0] wdata_i,
  output logic             gnt_o,
  output logic [31:0]      rdata_o,
  output logic             rvalid_o,
  input  wire logic        poke_i,
  input  wire logic [9:0]  poke_idx_i,
  input  wire logic [31:0] poke_data_i
);

  logic [31:0] mem [1024];
  // byte addresses of granted writes
  logic [31:0] write_log [$];
  logic        gnt_roll_q;
  logic [9:0]  idx;

  // type nibble 1, so no fill word is an EOP
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {4'h1, i[9:0], 8'h5a, i[9:0]};
    end
  end

  assign idx   = addr_i[11:2];
  assign gnt_o = req_i && gnt_roll_q;

  always @(posedge system_clk_i or negedge system_rst_ni) begin
    if (!system_rst_ni) begin
      gnt_roll_q <= 1'b1;
      rvalid_o   <= 1'b0;
      rdata_o    <= '0;
    end else begin
      // about three grants in four
      gnt_roll_q <= ($urandom % 4) != 0;
      rvalid_o   <= gnt_o && wen_i;
      if (gnt_o && wen_i) begin
        rdata_o <= mem[idx];
      end
      if (gnt_o && !wen_i) begin
        mem[idx] <= wdata_i;
        write_log.push_back(addr_i);
      end
      if (poke_i) begin
        mem[poke_idx_i] <= poke_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_evt_streamer.sv ====
// testbench for the event streamer: load, store and shared-port runs against a TCDM model
// assertions check the results; one line per test and a closing count line are printed
`timescale 1ns/1ns
`default_nettype none

module tb_evt_streamer;

  // words moved by tests 2 to 5, with 40 cycles allowed for each
  localparam int total_words = 12 + 16 + 10 + 16;
  localparam int cycle_limit = 40 * total_words;
  localparam logic [4:0] reset_code = 5'h00;
  localparam logic [4:0] idle_code  = 5'h01;

  logic                      system_clk_i;
  logic                      system_rst_ni;
  logic                      tcdm_req_o;
  logic                      tcdm_gnt_i;
  evt_streamer_pkg::addr_t   tcdm_add_o;
  logic                      tcdm_wen_o;
  logic [3:0]                tcdm_be_o;
  evt_streamer_pkg::word_t   tcdm_data_o;
  evt_streamer_pkg::word_t   tcdm_r_data_i;
  logic                      tcdm_r_valid_i;
  logic                      ld_arm_i;
  logic                      ld_start_i;
  logic                      ld_end_mode_i;
  evt_streamer_pkg::addr_t   ld_start_addr_i;
  evt_streamer_pkg::addr_t   ld_addr_step_i;
  evt_streamer_pkg::addr_t   ld_end_addr_i;
  evt_streamer_pkg::count_t  ld_tran_size_i;
  logic                      src_valid_o;
  logic                      src_ready_i;
  evt_streamer_pkg::word_t   src_evt_o;
  evt_streamer_pkg::status_t ld_status_o;
  logic                      st_arm_i;
  logic                      st_start_i;
  logic                      st_end_mode_i;
  evt_streamer_pkg::addr_t   st_start_addr_i;
  evt_streamer_pkg::addr_t   st_addr_step_i;
  evt_streamer_pkg::addr_t   st_end_addr_i;
  evt_streamer_pkg::count_t  st_tran_size_i;
  logic                      dst_valid_i;
  logic                      dst_ready_o;
  evt_streamer_pkg::word_t   dst_evt_i;
  evt_streamer_pkg::status_t st_status_o;
  logic                      poke_i;
  logic [9:0]                poke_idx_i;
  logic [31:0]               poke_data_i;
  logic                      ready_rand_en;
  logic [31:0]               got_q [$];
  logic [31:0]               sent_q [$];
  int                        errors;
  int                        tests_run;
  int                        tests_ok;
  int                        stall_cnt;
  int                        cycle_cnt;
  int                        seed_val;
  int                        err_base;
  int                        got_base;
  int                        log_base;

  evt_streamer_top u_dut (.*);

  tb_tcdm_model u_mem (
    .system_clk_i  (system_clk_i),
    .system_rst_ni (system_rst_ni),
    .req_i         (tcdm_req_o),
    .addr_i        (tcdm_add_o),
    .wen_i         (tcdm_wen_o),
    .wdata_i       (tcdm_data_o),
    .gnt_o         (tcdm_gnt_i),
    .rdata_o       (tcdm_r_data_i),
    .rvalid_o      (tcdm_r_valid_i),
    .poke_i        (poke_i),
    .poke_idx_i    (poke_idx_i),
    .poke_data_i   (poke_data_i)
  );

  always #2 system_clk_i = ~system_clk_i;

  // random back pressure on the outgoing stream
  initial begin
    src_ready_i = 1'b0;
    forever begin
      @(posedge system_clk_i);
      #1;
      src_ready_i = ready_rand_en && (($urandom % 2) == 1);
    end
  end

  // outgoing words and stalls, sampled mid-cycle
  always @(negedge system_clk_i) begin
    if (system_rst_ni && src_valid_o) begin
      if (src_ready_i) begin
        got_q.push_back(src_evt_o);
      end else begin
        stall_cnt++;
      end
    end
  end

  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    src_valid_o && !src_ready_i |=> src_valid_o && $stable(src_evt_o))
  else begin
    $display("MISMATCH at %0t: stalled outgoing word changed or was dropped", $time);
    errors++;
  end

  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    ld_status_o[4] |-> !src_valid_o)
  else begin
    $display("MISMATCH at %0t: word offered after the load transfer end", $time);
    errors++;
  end

  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    ld_status_o[4] && !ld_start_i |=> ld_status_o == idle_code)
  else begin
    $display("MISMATCH at %0t: load status %h did not return to idle", $time, ld_status_o);
    errors++;
  end

  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    st_status_o[4] && !st_start_i |=> st_status_o == idle_code)
  else begin
    $display("MISMATCH at %0t: store status %h did not return to idle", $time, st_status_o);
    errors++;
  end

  assert property (@(posedge system_clk_i) disable iff (!system_rst_ni)
    (dst_ready_o |-> dst_valid_i) and (tcdm_req_o |-> tcdm_be_o == 4'hf))
  else begin
    $display("MISMATCH at %0t: dst ready without valid or partial byte enable", $time);
    errors++;
  end

  task automatic tick();
    @(posedge system_clk_i);
    #1;
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return u_mem.mem[addr[11:2]];
  endfunction

  task automatic check_load(input string name, input logic [31:0] start,
                            input logic [31:0] step, input int n, input int base);
    check_word({name, " word count"}, 32'(got_q.size() - base), 32'(n));
    for (int i = 0; i < n && base + i < got_q.size(); i++) begin
      check_word($sformatf("%s word %0d", name, i), got_q[base + i], mem_word(start + i * step));
    end
  endtask

  // data in order, and exactly these addresses written
  task automatic check_store(input string name, input logic [31:0] start,
                             input logic [31:0] step, input int n, input int base);
    check_word({name, " write count"}, 32'(u_mem.write_log.size() - base), 32'(n));
    for (int i = 0; i < n && base + i < u_mem.write_log.size(); i++) begin
      check_word($sformatf("%s write address %0d", name, i), u_mem.write_log[base + i],
                 start + i * step);
      check_word($sformatf("%s word %0d", name, i), mem_word(start + i * step), sent_q[i]);
    end
  endtask

  task automatic send_dst_words(input int n);
    logic [31:0] word;
    for (int i = 0; i < n; i++) begin
      repeat ($urandom % 3) tick();
      word = $urandom;
      dst_evt_i = word;
      dst_valid_i = 1'b1;
      do @(negedge system_clk_i); while (!dst_ready_o);
      sent_q.push_back(word);
      tick();
      dst_valid_i = 1'b0;
    end
  endtask

  task automatic finish_load();
    do @(negedge system_clk_i); while (!ld_status_o[4]);
    tick();
    ld_start_i = 1'b0;
    do @(negedge system_clk_i); while (ld_status_o != idle_code);
  endtask

  task automatic finish_store();
    do @(negedge system_clk_i); while (!st_status_o[4]);
    tick();
    st_start_i = 1'b0;
    do @(negedge system_clk_i); while (st_status_o != idle_code);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge system_clk_i);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles: a transfer never ended", cycle_limit);
    $display("sim failed");
    $finish;
  end

  initial begin
    seed_val        = $urandom(32'h9aa);
    system_clk_i    = 1'b0;
    system_rst_ni   = 1'b0;
    ld_arm_i        = 1'b0;
    ld_start_i      = 1'b0;
    ld_end_mode_i   = 1'b0;
    ld_start_addr_i = '0;
    ld_addr_step_i  = '0;
    ld_end_addr_i   = '0;
    ld_tran_size_i  = '0;
    st_arm_i        = 1'b0;
    st_start_i      = 1'b0;
    st_end_mode_i   = 1'b0;
    st_start_addr_i = '0;
    st_addr_step_i  = '0;
    st_end_addr_i   = '0;
    st_tran_size_i  = '0;
    dst_valid_i     = 1'b0;
    dst_evt_i       = '0;
    poke_i          = 1'b0;
    poke_idx_i      = '0;
    poke_data_i     = '0;
    ready_rand_en   = 1'b0;
    repeat (10) @(posedge system_clk_i);
    #1;
    system_rst_ni = 1'b1;

    err_base = errors;
    @(negedge system_clk_i);
    check_word("tcdm_req_o", 32'(tcdm_req_o), 32'h0);
    check_word("src_valid_o", 32'(src_valid_o), 32'h0);
    check_word("dst_ready_o", 32'(dst_ready_o), 32'h0);
    check_word("ld_status_o", 32'(ld_status_o), 32'(reset_code));
    check_word("st_status_o", 32'(st_status_o), 32'(reset_code));
    tick();
    ld_arm_i = 1'b1;
    st_arm_i = 1'b1;
    do @(negedge system_clk_i); while (ld_status_o != idle_code || st_status_o != idle_code);
    report_test("reset and arm", err_base);

    err_base = errors;
    ready_rand_en = 1'b1;
    tick();
    ld_end_mode_i   = 1'b0;
    ld_start_addr_i = 32'h100;
    ld_addr_step_i  = 32'h8;
    ld_tran_size_i  = 16'd12;
    got_base = got_q.size();
    ld_start_i = 1'b1;
    finish_load();
    check_load("size load", 32'h100, 32'h8, 12, got_base);
    report_test("load by size", err_base);

    // EOP word at position 5 of a 16-word block
    err_base = errors;
    tick();
    poke_i      = 1'b1;
    poke_idx_i  = 10'h85;
    poke_data_i = 32'hf00d_0085;
    tick();
    poke_i          = 1'b0;
    ld_end_mode_i   = 1'b1;
    ld_start_addr_i = 32'h200;
    ld_addr_step_i  = 32'h4;
    ld_end_addr_i   = 32'h240;
    got_base = got_q.size();
    ld_start_i = 1'b1;
    finish_load();
    repeat (4) tick();
    check_load("eop load", 32'h200, 32'h4, 6, got_base);
    report_test("load with eop", err_base);

    err_base = errors;
    tick();
    st_end_mode_i   = 1'b1;
    st_start_addr_i = 32'h400;
    st_addr_step_i  = 32'h4;
    st_end_addr_i   = 32'h428;
    sent_q.delete();
    log_base = u_mem.write_log.size();
    st_start_i = 1'b1;
    send_dst_words(10);
    finish_store();
    check_store("end-address store", 32'h400, 32'h4, 10, log_base);
    report_test("store by end address", err_base);

    // both engines on disjoint regions
    err_base = errors;
    tick();
    ld_end_mode_i   = 1'b1;
    ld_start_addr_i = 32'h300;
    ld_addr_step_i  = 32'h4;
    ld_end_addr_i   = 32'h320;
    st_end_mode_i   = 1'b0;
    st_start_addr_i = 32'h800;
    st_addr_step_i  = 32'h4;
    st_tran_size_i  = 16'd8;
    sent_q.delete();
    log_base = u_mem.write_log.size();
    got_base = got_q.size();
    ld_start_i = 1'b1;
    st_start_i = 1'b1;
    fork
      begin
        send_dst_words(8);
        finish_store();
      end
      finish_load();
    join
    check_load("shared load", 32'h300, 32'h4, 8, got_base);
    check_store("shared store", 32'h800, 32'h4, 8, log_base);
    report_test("load and store together", err_base);

    err_base = errors;
    assert (stall_cnt > 0) else begin
      $display("the outgoing stream never stalled, so word holding was not exercised");
      errors++;
    end
    report_test("stall hold and idle return", err_base);

    $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_ok, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== evt_streamer.f ====
+incdir+.
evt_streamer_pkg.sv
tcdm_port_if.sv
tcdm_arbiter.sv
evt_load_engine.sv
evt_store_engine.sv
evt_streamer_top.sv
tb_tcdm_model.sv
tb_evt_streamer.sv

// ==== Makefile ====
# build and run the event streamer testbench with Verilator

sim:
	verilator --binary --timing --assert -Wno-fatal -f evt_streamer.f \
		--top-module tb_evt_streamer -Mdir obj_dir -o tb_evt_streamer
	./obj_dir/tb_evt_streamer | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
